/* all.f */
+incdir+common
common/vid_pkg.sv
rtl/video_timing.sv
video_ram/vram_bank.sv
video_ram/pf_vscroll.sv
video_ram/video_ram.sv
rtl/video_subsys.sv
tb/video_checker.sv
tb/tb_video.sv

/* common/vid_defs.svh */
// Width and raster constants for the video RAM section, included by every RTL file that sizes by them
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// Data path
`define VID_DATA_W 16 // One video RAM word
`define VID_ADDR_W 12 // Word address inside one bank

// Raster totals, counted in pixels and lines
`define VID_H_TOTAL 456
`define VID_V_TOTAL 262
`define VID_V_ACTIVE 240 // Lines with vblank_n high

// Horizontal sync window
`define VID_HSYNC_START 376 // First pixel of the pulse
`define VID_HSYNC_LEN 32

`endif

/* common/vid_pkg.sv */
// Shared types for the video RAM section: access slot encoding and the two decodings of a RAM word
package vid_pkg;

	// Four fixed access slots, one per clock, repeating every pixel
	typedef enum logic [1:0] {
		SLOT_PF  = 2'd0, // Playfield tile fetch, bank 0
		SLOT_MO  = 2'd1, // Motion-object link fetch, bank 1
		SLOT_AL  = 2'd2, // Alphanumerics fetch, bank 1
		SLOT_CPU = 2'd3 // CPU read or write, either bank
	} slot_e;

	// One RAM word, read through the view that matches the fetching slot
	typedef union packed {
		struct packed {
			logic       hflip; // Bit 15
			logic       pp18; // Bit 14, picture bank
			logic [7:0] attr;
			logic [5:0] pp_hi; // Picture bits
		} pf;
		struct packed {
			logic [9:0] attr;
			logic [5:0] link; // Next motion object
		} mo;
	} vram_word_u;

endpackage

/* rtl/video_subsys.sv */
// Top of the video memory section: timing generator driving the shared video RAM block
`timescale 1ns/1ps
`include "vid_defs.svh"

module video_subsys (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_req,
	input  logic                   cpu_we,
	input  logic [13:0]            cpu_addr,
	input  logic [`VID_DATA_W-1:0] cpu_wdata,
	output vid_pkg::slot_e         slot,
	output logic [8:0]             hpos,
	output logic [8:0]             vpos,
	output logic                   hsync,
	output logic                   vblank_n,
	output logic [`VID_DATA_W-1:0] cpu_rdata,
	output logic                   cpu_ack,
	output logic                   pf_hflip,
	output logic                   pp18,
	output logic [5:0]             pp_hi,
	output logic [2:0]             pp_lo,
	output logic [5:0]             pfv,
	output logic [5:0]             mo_link,
	output logic [`VID_DATA_W-1:0] al_data,
	output logic                   snd_reset_n,
	output logic                   tb_test,
	output logic                   pp19,
	output logic                   tb_reset_n,
	output logic                   alpha_bank
);

	video_timing u_timing (
		.clk      (clk),
		.reset    (reset),
		.slot     (slot),
		.hpos     (hpos),
		.vpos     (vpos),
		.hsync    (hsync),
		.vblank_n (vblank_n)
	);

	// Timing outputs double as the slot and beam inputs of the RAM block
	video_ram u_video_ram (
		.clk         (clk),
		.reset       (reset),
		.slot        (slot),
		.hpos        (hpos),
		.vpos        (vpos),
		.hsync       (hsync),
		.vblank_n    (vblank_n),
		.cpu_req     (cpu_req),
		.cpu_we      (cpu_we),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_rdata   (cpu_rdata),
		.cpu_ack     (cpu_ack),
		.pf_hflip    (pf_hflip),
		.pp18        (pp18),
		.pp_hi       (pp_hi),
		.pp_lo       (pp_lo),
		.pfv         (pfv),
		.mo_link     (mo_link),
		.al_data     (al_data),
		.snd_reset_n (snd_reset_n),
		.tb_test     (tb_test),
		.pp19        (pp19),
		.tb_reset_n  (tb_reset_n),
		.alpha_bank  (alpha_bank)
	);

endmodule

/* rtl/video_timing.sv */
// Raster timing generator: slot phase, beam counters, hsync and vblank for the video RAM block
`timescale 1ns/1ps
`include "vid_defs.svh"

module video_timing (
	input  logic           clk,
	input  logic           reset,
	output vid_pkg::slot_e slot,
	output logic [8:0]     hpos,
	output logic [8:0]     vpos,
	output logic           hsync,
	output logic           vblank_n
);

	logic [1:0] phase; // Slot counter, one step per clock
	logic       pix_end; // Last slot of a pixel
	logic       line_end; // Last pixel of a line
	logic       frame_end; // Last line of a frame

	assign pix_end   = (phase == 2'd3);
	assign line_end  = (hpos == 9'(`VID_H_TOTAL - 1));
	assign frame_end = (vpos == 9'(`VID_V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 2'd0; // Start on the playfield slot
			hpos  <= '0;
			vpos  <= '0;
		end else begin
			phase <= phase + 2'd1;
			if (pix_end) begin // Pixel step after the CPU slot
				if (line_end) begin
					hpos <= '0;
					if (frame_end)
						vpos <= '0;
					else
						vpos <= vpos + 9'd1;
				end else begin
					hpos <= hpos + 9'd1;
				end
			end
		end
	end

	assign slot = vid_pkg::slot_e'(phase);

	// Sync window on the pixel count
	assign hsync = (hpos >= 9'(`VID_HSYNC_START)) &&
		(hpos < 9'(`VID_HSYNC_START + `VID_HSYNC_LEN));
	assign vblank_n = (vpos < 9'(`VID_V_ACTIVE)); // Low through vertical blank

	// Every clock moves to the next slot, CPU wrapping back to playfield
	a_slot_step: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> slot == vid_pkg::slot_e'($past(slot) + 2'd1));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the video RAM testbench with Verilator, runs it and searches the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_video -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_video | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
	exit 0
else
	echo "Pass line not found in $LOG"
	exit 1
fi

/* tb/tb_video.sv */
// Testbench top for the video memory section: clock, reset, CPU stimulus and the end-of-run verdict
`timescale 1ns/1ps
`include "vid_defs.svh"

module tb_video;

	localparam int LINE = `VID_H_TOTAL * 4; // Clocks per raster line

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   cpu_req;
	logic                   cpu_we;
	logic [13:0]            cpu_addr;
	logic [`VID_DATA_W-1:0] cpu_wdata;
	vid_pkg::slot_e         slot;
	logic [8:0]             hpos;
	logic [8:0]             vpos;
	logic                   hsync;
	logic                   vblank_n;
	logic [`VID_DATA_W-1:0] cpu_rdata;
	logic                   cpu_ack;
	logic                   pf_hflip;
	logic                   pp18;
	logic [5:0]             pp_hi;
	logic [2:0]             pp_lo;
	logic [5:0]             pfv;
	logic [5:0]             mo_link;
	logic [`VID_DATA_W-1:0] al_data;
	logic                   snd_reset_n;
	logic                   tb_test;
	logic                   pp19;
	logic                   tb_reset_n;
	logic                   alpha_bank;
	int                     checks;
	int                     errors;
	logic                   timed_out;
	integer                 seed;
	logic [31:0]            r;
	logic [13:0]            addrs [$]; // Written RAM addresses for read-back
	logic [5:0]             row; // First tile row after the scroll load
	logic [5:0]             rr;

	always #4 clk = ~clk; // 8 ns period

	video_subsys u_video_subsys (.*);

	video_checker u_checker (.*); // Compares every DUT output against the models

	// One CPU access, held until ack, then dropped for at least a cycle
	task automatic cpu_access(input logic we, input logic [13:0] addr, input logic [15:0] data);
		@(negedge clk);
		cpu_req   = 1'b1;
		cpu_we    = we;
		cpu_addr  = addr;
		cpu_wdata = data;
		do
			@(negedge clk);
		while (!cpu_ack);
		cpu_req = 1'b0;
	endtask

	initial begin
		seed      = 46232;
		reset     = 1'b1;
		cpu_req   = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk); // Reset values checked here

		// Random words to random places in both banks, then read back
		for (int i = 0; i < 48; i++) begin
			r = $random(seed);
			addrs.push_back({1'b0, r[12:0]});
			cpu_access(1'b1, {1'b0, r[12:0]}, r[31:16]);
		end
		foreach (addrs[i])
			cpu_access(1'b0, addrs[i], 16'h0000);

		// Control register with motion bank 101
		r = $random(seed);
		cpu_access(1'b1, 14'h2001, {8'h00, r[7:6], 3'b101, r[2:0]});
		cpu_access(1'b0, 14'h2001, 16'h0000); // Register read-back

		// Scroll load, then let a few active lines step it
		r = $random(seed);
		cpu_access(1'b1, 14'h2000, {7'd0, r[8:0]});
		cpu_access(1'b0, 14'h2000, 16'h0000); // Count read-back
		row = r[8:3];
		repeat (3 * LINE) @(negedge clk);

		// Motion region of bank 101, every link and hpos variant
		for (int i = 0; i < 256; i++) begin
			r = $random(seed);
			cpu_access(1'b1, {6'b010101, 8'(i)}, r[15:0]);
		end

		// Tile rows the scroll counter passes through next
		for (int k = 0; k < 4; k++) begin
			rr = row + 6'(k);
			for (int c = 0; c < 64; c++) begin
				r = $random(seed);
				cpu_access(1'b1, {2'b00, rr, 6'(c)}, r[15:0]);
			end
		end

		// Alphanumerics rows of the first lines, bank 1 upper half
		for (int k = 0; k < 2; k++) begin
			for (int c = 0; c < 64; c++) begin
				r = $random(seed);
				cpu_access(1'b1, {3'b011, 5'(k), 6'(c)}, r[15:0]);
			end
		end
		repeat (3 * LINE) @(negedge clk); // Fetches check against the filled words

		$display("Checks: %0d compared, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	always @(posedge clk) begin
		if (timed_out) begin
			$display("Run stopped: cycle limit reached before the tests finished");
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

endmodule

/* tb/video_checker.sv */
// Testbench checker: follows CPU traffic into shadow state and compares every DUT output each clock
`timescale 1ns/1ps
`include "vid_defs.svh"

module video_checker (
	input  logic                   clk,
	input  logic                   reset,
	input  vid_pkg::slot_e         slot,
	input  logic [8:0]             hpos,
	input  logic [8:0]             vpos,
	input  logic                   hsync,
	input  logic                   vblank_n,
	input  logic                   cpu_req,
	input  logic                   cpu_we,
	input  logic [13:0]            cpu_addr,
	input  logic [`VID_DATA_W-1:0] cpu_wdata,
	input  logic [`VID_DATA_W-1:0] cpu_rdata,
	input  logic                   cpu_ack,
	input  logic                   pf_hflip,
	input  logic                   pp18,
	input  logic [5:0]             pp_hi,
	input  logic [2:0]             pp_lo,
	input  logic [5:0]             pfv,
	input  logic [5:0]             mo_link,
	input  logic [`VID_DATA_W-1:0] al_data,
	input  logic                   snd_reset_n,
	input  logic                   tb_test,
	input  logic                   pp19,
	input  logic                   tb_reset_n,
	input  logic                   alpha_bank,
	output int                     checks,
	output int                     errors,
	output logic                   timed_out
);

	localparam int LIMIT = 30 * `VID_H_TOTAL * 4 * 11 / 10; // 30 lines plus 10 percent

	bit [15:0]      shadow [8192]; // Both banks, bank bit on top
	bit             written [8192];
	int             n_checks = 0;
	int             n_errors = 0;
	int             cycles = 0;
	int             pulses; // Active line steps since the last load
	int             wait_cnt; // Request cycles before ack
	logic [8:0]     load_val;
	logic [7:0]     ctrl_ref;
	logic [5:0]     link_ref;
	logic           hsync_q;
	logic           served; // CPU slot with a request last cycle
	logic           acc_we;
	logic [13:0]    acc_addr;
	logic [15:0]    acc_data;
	logic [12:0]    fetch_a; // Address of the fetch whose data is due
	vid_pkg::slot_e slot_q;
	logic [1:0]     ph_ref; // Slot phase model
	int             h_ref; // Pixel model
	int             v_ref; // Line model
	logic           hs_ref;
	logic           vb_ref;
	logic [7:0]     tile_exp; // Tile latch contents expected
	logic           tile_known;
	logic [15:0]    al_exp;
	logic           al_known;

	assign checks    = n_checks;
	assign errors    = n_errors;
	assign timed_out = (cycles > LIMIT);

	function automatic logic [8:0] scroll_ref(input logic [8:0] base, input int n);
		scroll_ref = 9'((int'(base) + n) % 512); // Wraps like the nine-bit counter
	endfunction

	// Playfield view: flip, bank bit, picture bits
	function automatic logic [7:0] tile_ref(input logic [15:0] raw);
		vid_pkg::vram_word_u w;
		w        = raw;
		tile_ref = {w.pf.hflip, w.pf.pp18, w.pf.pp_hi};
	endfunction

	function automatic logic [5:0] link_of(input logic [15:0] raw);
		vid_pkg::vram_word_u w;
		w       = raw;
		link_of = w.mo.link;
	endfunction

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("Fail %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	always @(posedge clk) begin
		logic [8:0]     scroll;
		logic [8:0]     hr;
		logic [8:0]     vr;
		vid_pkg::slot_e s_ref;
		cycles++;
		if (reset) begin
			pulses     = 0;
			wait_cnt   = 0;
			load_val   = '0;
			ctrl_ref   = '0;
			link_ref   = '0;
			hsync_q    = 1'b0;
			served     = 1'b0;
			slot_q     = vid_pkg::SLOT_CPU; // Nothing fetched yet
			fetch_a    = '0;
			ph_ref     = 2'd0;
			h_ref      = 0;
			v_ref      = 0;
			tile_exp   = '0; // Tile latch cleared by reset
			tile_known = 1'b1;
			al_known   = 1'b0;
		end else begin
			// Raster model, one slot per clock and one pixel per slot round
			s_ref  = vid_pkg::slot_e'(ph_ref);
			hr     = 9'(h_ref);
			vr     = 9'(v_ref);
			hs_ref = (h_ref >= `VID_HSYNC_START) &&
				(h_ref < `VID_HSYNC_START + `VID_HSYNC_LEN);
			vb_ref = (v_ref < `VID_V_ACTIVE);
			compare("slot", 16'(ph_ref), 16'(slot));
			compare("hpos", 16'(h_ref), 16'(hpos));
			compare("vpos", 16'(v_ref), 16'(vpos));
			compare("hsync", 16'(hs_ref), 16'(hsync));
			compare("vblank_n", 16'(vb_ref), 16'(vblank_n));

			scroll = scroll_ref(load_val, pulses);
			compare("scroll", 16'(scroll), 16'({pfv, pp_lo}));
			compare("ctrl", 16'({ctrl_ref[7:6], ctrl_ref[2:0]}),
				16'({snd_reset_n, tb_test, pp19, tb_reset_n, alpha_bank}));

			// Ack one cycle after the serving slot, read data with it
			if (served) begin
				if (!cpu_ack) begin
					n_errors++;
					$display("At %0t cpu_ack did not follow a served request", $time);
				end else if (!acc_we) begin
					if (!acc_addr[13])
						compare("cpu_rdata", shadow[acc_addr[12:0]], cpu_rdata);
					else if (acc_addr[0])
						compare("cpu_rdata", {8'h00, ctrl_ref}, cpu_rdata);
					else
						compare("cpu_rdata", 16'(scroll), cpu_rdata);
				end
				if (acc_we && !acc_addr[13]) begin
					shadow[acc_addr[12:0]]  = acc_data; // Committed on ack
					written[acc_addr[12:0]] = 1'b1;
				end
			end else if (cpu_ack) begin
				n_errors++;
				$display("At %0t cpu_ack rose with no request served", $time);
			end
			if (cpu_ack) begin
				if (wait_cnt < 1 || wait_cnt > 4) begin
					n_errors++;
					$display("At %0t ack latency %0d is outside 1 to 4", $time, wait_cnt);
				end
				wait_cnt = 0;
			end else if (cpu_req) begin
				wait_cnt++;
			end

			// Fetch data lands one cycle after its slot, then the latch holds it
			if (slot_q == vid_pkg::SLOT_PF) begin
				tile_known = written[fetch_a];
				tile_exp   = tile_ref(shadow[fetch_a]);
			end
			if (tile_known)
				compare("pf tile", 16'(tile_exp), 16'({pf_hflip, pp18, pp_hi}));
			if (slot_q == vid_pkg::SLOT_MO && !written[fetch_a]) begin
				link_ref = mo_link; // Unwritten word, follow the chain
			end else begin
				if (slot_q == vid_pkg::SLOT_MO)
					link_ref = link_of(shadow[fetch_a]);
				compare("mo_link", 16'(link_ref), 16'(mo_link));
			end
			if (slot_q == vid_pkg::SLOT_AL) begin
				al_known = written[fetch_a];
				al_exp   = shadow[fetch_a];
			end
			if (al_known)
				compare("al_data", al_exp, al_data);

			case (s_ref)
				vid_pkg::SLOT_PF: fetch_a = {1'b0, scroll[8:3], hr[8:3]};
				vid_pkg::SLOT_MO: fetch_a = {2'b10, ctrl_ref[5:3], hr[2], ~hr[0], link_ref};
				vid_pkg::SLOT_AL: fetch_a = {2'b11, vr[7:3], hr[7:2]};
				default: fetch_a = fetch_a;
			endcase
			slot_q = s_ref;

			// Requests taken in this CPU slot
			served = (s_ref == vid_pkg::SLOT_CPU) && cpu_req;
			if (served) begin
				acc_we   = cpu_we;
				acc_addr = cpu_addr;
				acc_data = cpu_wdata;
			end
			if (served && cpu_we && cpu_addr[13] && !cpu_addr[0]) begin
				load_val = cpu_wdata[8:0]; // Load beats a line step
				pulses   = 0;
			end else if (hs_ref && !hsync_q && vb_ref) begin
				pulses++;
			end
			if (served && cpu_we && cpu_addr[13] && cpu_addr[0])
				ctrl_ref = cpu_wdata[7:0];
			hsync_q = hs_ref;

			// Pixel step after the CPU slot, line and frame wrap
			if (ph_ref == 2'd3) begin
				h_ref = (h_ref + 1) % `VID_H_TOTAL;
				if (h_ref == 0)
					v_ref = (v_ref + 1) % `VID_V_TOTAL;
			end
			ph_ref = ph_ref + 2'd1;
		end
	end

endmodule

/* video_ram/pf_vscroll.sv */
// Playfield vertical-scroll counter, loaded by a CPU register write and stepped once per active line
`timescale 1ns/1ps

module pf_vscroll (
	input  logic       clk,
	input  logic       reset,
	input  logic       load, // Scroll register write
	input  logic [8:0] load_value,
	input  logic       hsync,
	input  logic       vblank_n,
	output logic [2:0] pp_lo, // Line inside the tile
	output logic [5:0] pfv // Tile row
);

	logic [8:0] vcount; // Scrolled line number
	logic       hsync_d; // Previous hsync for the edge
	logic       line_step;

	// First cycle of a sync pulse on a visible line
	assign line_step = hsync & ~hsync_d & vblank_n;

	always_ff @(posedge clk) begin
		if (reset) begin
			vcount  <= '0;
			hsync_d <= 1'b0;
		end else begin
			hsync_d <= hsync;
			if (load)
				vcount <= load_value; // Load has priority over the step
			else if (line_step)
				vcount <= vcount + 9'd1; // Wraps at 512
		end
	end

	assign pp_lo = vcount[2:0];
	assign pfv   = vcount[8:3];

	// A load that meets a line step must still land the written value
	a_load_wins: assert property (@(posedge clk) disable iff (reset)
		load |=> vcount == $past(load_value));

endmodule

/* video_ram/video_ram.sv */
// Shared video RAM: per-slot address mux, bank steering, CPU port, fetch latches and control register
`timescale 1ns/1ps
`include "vid_defs.svh"

module video_ram (
	input  logic                   clk,
	input  logic                   reset,
	input  vid_pkg::slot_e         slot,
	input  logic [8:0]             hpos,
	input  logic [8:0]             vpos,
	input  logic                   hsync,
	input  logic                   vblank_n,
	input  logic                   cpu_req,
	input  logic                   cpu_we,
	input  logic [13:0]            cpu_addr, // Bit 13 register space, bit 12 bank
	input  logic [`VID_DATA_W-1:0] cpu_wdata,
	output logic [`VID_DATA_W-1:0] cpu_rdata,
	output logic                   cpu_ack,
	output logic                   pf_hflip,
	output logic                   pp18,
	output logic [5:0]             pp_hi,
	output logic [2:0]             pp_lo,
	output logic [5:0]             pfv,
	output logic [5:0]             mo_link,
	output logic [`VID_DATA_W-1:0] al_data,
	output logic                   snd_reset_n,
	output logic                   tb_test,
	output logic                   pp19,
	output logic                   tb_reset_n,
	output logic                   alpha_bank
);

	logic [`VID_ADDR_W-1:0] vram_addr; // Shared by both banks
	logic                   bank_sel; // Bank read in this slot
	logic                   cpu_serve; // CPU slot with a request
	logic                   we0, we1;
	logic                   reg_wr, vscroll_ld, ctrl_ld;
	logic [`VID_DATA_W-1:0] rdata0, rdata1;
	vid_pkg::vram_word_u    word0, word1; // Read data, decoded per slot
	vid_pkg::slot_e         slot_q; // Slot whose data is on rdata now
	logic                   cpu_bank_q, cpu_reg_q, cpu_ctl_q; // Read source for the ack cycle
	logic [7:0]             tile_q; // Flip, pp18 and picture bits held
	logic [5:0]             link_q; // Next motion object
	logic [`VID_DATA_W-1:0] al_q;
	logic [7:0]             ctrl_q; // Miscellaneous control register
	logic [2:0]             mpbs; // Motion picture bank

	assign cpu_serve = (slot == vid_pkg::SLOT_CPU) && cpu_req;
	assign mpbs      = ctrl_q[5:3];

	// Address and bank per slot
	always_comb begin
		case (slot)
			vid_pkg::SLOT_PF: begin
				vram_addr = {pfv, hpos[8:3]};
				bank_sel  = 1'b0;
			end
			vid_pkg::SLOT_MO: begin
				vram_addr = {1'b0, mpbs, hpos[2], ~hpos[0], link_q};
				bank_sel  = 1'b1;
			end
			vid_pkg::SLOT_AL: begin
				vram_addr = {1'b1, vpos[7:3], hpos[7:2]};
				bank_sel  = 1'b1;
			end
			default: begin // CPU
				vram_addr = cpu_addr[11:0];
				bank_sel  = cpu_addr[12];
			end
		endcase
	end

	// Write steering, RAM space only
	assign we0 = cpu_serve & cpu_we & ~cpu_addr[13] & ~bank_sel;
	assign we1 = cpu_serve & cpu_we & ~cpu_addr[13] & bank_sel;

	// Register space decode
	assign reg_wr     = cpu_serve & cpu_we & cpu_addr[13];
	assign vscroll_ld = reg_wr & ~cpu_addr[0];
	assign ctrl_ld    = reg_wr & cpu_addr[0];

	vram_bank u_bank0 (
		.clk   (clk),
		.addr  (vram_addr),
		.we    (we0),
		.wdata (cpu_wdata),
		.rdata (rdata0)
	);

	vram_bank u_bank1 (
		.clk   (clk),
		.addr  (vram_addr),
		.we    (we1),
		.wdata (cpu_wdata),
		.rdata (rdata1)
	);

	pf_vscroll u_vscroll (
		.clk        (clk),
		.reset      (reset),
		.load       (vscroll_ld),
		.load_value (cpu_wdata[8:0]),
		.hsync      (hsync),
		.vblank_n   (vblank_n),
		.pp_lo      (pp_lo),
		.pfv        (pfv)
	);

	assign word0 = rdata0;
	assign word1 = rdata1;

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_q  <= vid_pkg::SLOT_CPU; // No fetch data pending
			cpu_ack <= 1'b0;
			tile_q  <= '0;
			link_q  <= '0;
			ctrl_q  <= '0; // Sound and trackball held in reset
		end else begin
			slot_q  <= slot;
			cpu_ack <= cpu_serve; // One cycle after the CPU slot
			if (slot_q == vid_pkg::SLOT_PF)
				tile_q <= {word0.pf.hflip, word0.pf.pp18, word0.pf.pp_hi};
			if (slot_q == vid_pkg::SLOT_MO)
				link_q <= word1.mo.link;
			if (ctrl_ld)
				ctrl_q <= cpu_wdata[7:0];
		end
	end

	// Payload registers, no reset
	always_ff @(posedge clk) begin
		if (slot_q == vid_pkg::SLOT_AL)
			al_q <= rdata1;
		if (cpu_serve) begin
			cpu_bank_q <= cpu_addr[12];
			cpu_reg_q  <= cpu_addr[13];
			cpu_ctl_q  <= cpu_addr[0];
		end
	end

	// Fetch outputs follow the RAM in the data cycle, then hold
	assign {pf_hflip, pp18, pp_hi} = (slot_q == vid_pkg::SLOT_PF) ?
		{word0.pf.hflip, word0.pf.pp18, word0.pf.pp_hi} : tile_q;
	assign mo_link = (slot_q == vid_pkg::SLOT_MO) ? word1.mo.link : link_q;
	assign al_data = (slot_q == vid_pkg::SLOT_AL) ? rdata1 : al_q;

	// CPU read data, valid with cpu_ack
	always_comb begin
		if (!cpu_reg_q)
			cpu_rdata = cpu_bank_q ? rdata1 : rdata0;
		else if (cpu_ctl_q)
			cpu_rdata = {8'h00, ctrl_q};
		else
			cpu_rdata = {7'd0, pfv, pp_lo}; // Current scroll count
	end

	// Control bits, high to low
	assign snd_reset_n = ctrl_q[7];
	assign tb_test     = ctrl_q[6];
	assign pp19        = ctrl_q[2];
	assign tb_reset_n  = ctrl_q[1];
	assign alpha_bank  = ctrl_q[0];

	// Only one CPU slot per pixel, so acks never run back to back
	a_ack_single: assert property (@(posedge clk) disable iff (reset)
		cpu_ack |=> !cpu_ack);

endmodule

/* video_ram/vram_bank.sv */
// One 4K-word video RAM bank with synchronous write and a registered read port
`timescale 1ns/1ps
`include "vid_defs.svh"

module vram_bank (
	input  logic                   clk,
	input  logic [`VID_ADDR_W-1:0] addr,
	input  logic                   we,
	input  logic [`VID_DATA_W-1:0] wdata,
	output logic [`VID_DATA_W-1:0] rdata
);

	localparam int DEPTH = 1 << `VID_ADDR_W;

	// The four nibble-wide static RAMs of a bank, merged into one array
	logic [`VID_DATA_W-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata; // CPU slot only
		rdata <= mem[addr]; // Old word on a write cycle
	end

endmodule
